// File: hw/mips_pkg.sv
/*
 * MIPS pipeline shared definitions
 * word and register widths, ALU operations, exception causes,
 * forwarding selects, opcode and funct encodings, reset PC
 */
package mips_pkg;

    typedef logic [31:0] word_t;       // data, address or instruction
    typedef logic [4:0]  reg_addr_t;   // register number
    typedef logic [1:0]  fwd_sel_t;    // operand source in execute

    localparam word_t RESET_PC   = 32'h0040_0000;
    localparam int    DMEM_WORDS = 64;

    typedef logic [$clog2(DMEM_WORDS)-1:0] dmem_addr_t;   // data memory word index

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [2:0]
    {
        EXC_NONE       = 3'd0,
        EXC_ILLEGAL    = 3'd1,   // unknown opcode or funct
        EXC_OVERFLOW   = 3'd2,   // signed add/sub overflow
        EXC_MISALIGNED = 3'd3,   // lw/sw address not word aligned
        EXC_ZERO_WRITE = 3'd4    // destination is r0
    } exc_cause_t;

    localparam fwd_sel_t FWD_RF  = 2'd0;   // register file value
    localparam fwd_sel_t FWD_MEM = 2'd1;   // result leaving execute
    localparam fwd_sel_t FWD_WB  = 2'd2;   // result leaving memory

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

endpackage

// File: hw/mips_pipe_if.sv
/*
 * Pipeline stage interfaces
 * carry the combinational next-stage values between stages,
 * the consuming stage owns the capturing register
 */
`timescale 1ns/1ps

interface id_ex_if import mips_pkg::*; ();
    logic       valid;
    word_t      pc;
    reg_addr_t  rs;
    reg_addr_t  rt;
    word_t      rs_val;
    word_t      rt_val;
    word_t      imm;        // sign extended
    reg_addr_t  dest;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       is_beq;
    logic       is_bne;
    exc_cause_t cause;

    modport src (output valid, pc, rs, rt, rs_val, rt_val, imm, dest, alu_op, use_imm,
                 reg_write, mem_read, mem_write, is_beq, is_bne, cause);
    modport dst (input valid, pc, rs, rt, rs_val, rt_val, imm, dest, alu_op, use_imm,
                 reg_write, mem_read, mem_write, is_beq, is_bne, cause);
endinterface

interface ex_mem_if import mips_pkg::*; ();
    logic       valid;
    word_t      pc;
    word_t      alu_result;
    word_t      store_data;
    reg_addr_t  dest;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    exc_cause_t cause;

    modport src (output valid, pc, alu_result, store_data, dest, reg_write,
                 mem_read, mem_write, cause);
    modport dst (input valid, pc, alu_result, store_data, dest, reg_write,
                 mem_read, mem_write, cause);
endinterface

interface mem_wb_if import mips_pkg::*; ();
    logic      valid;
    word_t     pc;
    word_t     result;
    reg_addr_t dest;
    logic      reg_write;

    modport src (output valid, pc, result, dest, reg_write);
    modport dst (input valid, pc, result, dest, reg_write);
endinterface

// File: hw/mips_fetch.sv
/*
 * Fetch stage
 * program counter, redirected by exception, then branch, then held on stall
 */
`timescale 1ns/1ps

module mips_fetch
    import mips_pkg::*;
(
    input  logic  SYS_clk,
    input  logic  SYS_reset,
    input  logic  stall,
    input  logic  branch_taken,
    input  word_t branch_target,
    input  logic  exc_flush,
    input  word_t exc_target,
    output word_t pc
);

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc <= RESET_PC;
        end
        else if (exc_flush)
        begin
            pc <= exc_target;        // resume after the faulting instruction
        end
        else if (branch_taken)
        begin
            pc <= branch_target;
        end
        else if (!stall)
        begin
            pc <= pc + 32'd4;
        end
    end

endmodule

// File: hw/mips_decode.sv
/*
 * Decode stage
 * IF/ID register, opcode and funct decode with illegal and r0-write
 * detection, 32-entry register file with write-through bypass
 */
`timescale 1ns/1ps

module mips_decode
    import mips_pkg::*;
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    input  word_t     instr,
    input  word_t     fetch_pc,
    input  logic      stall,
    input  logic      branch_taken,
    input  logic      exc_flush,
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,
    id_ex_if.src      id_ex
);
    logic  q_valid;
    word_t q_instr;
    word_t q_pc;
    word_t regs [32];
    logic  legal;

    function automatic word_t rf_read(reg_addr_t addr, logic we, reg_addr_t waddr,
                                      word_t wdata, word_t stored);
        if (addr == '0)
        begin
            return '0;
        end
        return (we && waddr == addr) ? wdata : stored;   // writer three ahead
    endfunction

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            q_valid <= 1'b0;
        end
        else if (branch_taken || exc_flush)
        begin
            q_valid <= 1'b0;              // squash
        end
        else if (!stall)
        begin
            q_valid <= 1'b1;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
        begin
            q_instr <= instr;
            q_pc    <= fetch_pc;
        end
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (rf_we && rf_waddr != '0)
        begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    always_comb
    begin
        legal           = 1'b1;
        id_ex.alu_op    = ALU_ADD;
        id_ex.use_imm   = 1'b0;
        id_ex.reg_write = 1'b0;
        id_ex.mem_read  = 1'b0;
        id_ex.mem_write = 1'b0;
        id_ex.is_beq    = 1'b0;
        id_ex.is_bne    = 1'b0;
        id_ex.dest      = q_instr[20:16];   // rt for I-type
        case (q_instr[31:26])
            OP_RTYPE:
            begin
                id_ex.reg_write = 1'b1;
                id_ex.dest      = q_instr[15:11];
                case (q_instr[5:0])
                    FN_ADD:  id_ex.alu_op = ALU_ADD;
                    FN_SUB:  id_ex.alu_op = ALU_SUB;
                    FN_AND:  id_ex.alu_op = ALU_AND;
                    FN_OR:   id_ex.alu_op = ALU_OR;
                    FN_SLT:  id_ex.alu_op = ALU_SLT;
                    default: legal = 1'b0;
                endcase
            end
            OP_ADDI:
            begin
                id_ex.use_imm   = 1'b1;
                id_ex.reg_write = 1'b1;
            end
            OP_LW:
            begin
                id_ex.use_imm   = 1'b1;
                id_ex.reg_write = 1'b1;
                id_ex.mem_read  = 1'b1;
            end
            OP_SW:
            begin
                id_ex.use_imm   = 1'b1;
                id_ex.mem_write = 1'b1;
            end
            OP_BEQ:  id_ex.is_beq = 1'b1;
            OP_BNE:  id_ex.is_bne = 1'b1;
            default: legal = 1'b0;
        endcase

        if (!legal)
        begin
            id_ex.cause = EXC_ILLEGAL;
        end
        else if (id_ex.reg_write && id_ex.dest == '0)
        begin
            id_ex.cause = EXC_ZERO_WRITE;
        end
        else
        begin
            id_ex.cause = EXC_NONE;
        end
    end

    // all-zero word is a nop, a stall sends a bubble on
    assign id_ex.valid  = q_valid && (q_instr != '0) && !stall;
    assign id_ex.pc     = q_pc;
    assign id_ex.rs     = q_instr[25:21];
    assign id_ex.rt     = q_instr[20:16];
    assign id_ex.imm    = {{16{q_instr[15]}}, q_instr[15:0]};
    assign id_ex.rs_val = rf_read(id_ex.rs, rf_we, rf_waddr, rf_wdata, regs[id_ex.rs]);
    assign id_ex.rt_val = rf_read(id_ex.rt, rf_we, rf_waddr, rf_wdata, regs[id_ex.rt]);

endmodule

// File: hw/mips_hazard.sv
/*
 * Hazard unit
 * load-use stall and operand forwarding selects for the instruction
 * about to enter execute
 */
`timescale 1ns/1ps

module mips_hazard
    import mips_pkg::*;
(
    id_ex_if.dst      id_ex,
    ex_mem_if.dst     ex_mem,
    mem_wb_if.dst     mem_wb,
    input  reg_addr_t fetched_rs,
    input  reg_addr_t fetched_rt,
    output logic      stall,
    output fwd_sel_t  fwd_a,
    output fwd_sel_t  fwd_b
);
    logic mem_fwd;
    logic wb_fwd;

    // load in execute, its data is not ready for the instruction in decode
    assign stall = ex_mem.valid && ex_mem.mem_read && ex_mem.dest != '0 &&
                   (ex_mem.dest == fetched_rs || ex_mem.dest == fetched_rt);

    assign mem_fwd = ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read &&
                     ex_mem.dest != '0;
    assign wb_fwd  = mem_wb.valid && mem_wb.reg_write && mem_wb.dest != '0;

    // younger producer wins
    assign fwd_a = (mem_fwd && ex_mem.dest == id_ex.rs) ? FWD_MEM :
                   (wb_fwd && mem_wb.dest == id_ex.rs)  ? FWD_WB  : FWD_RF;
    assign fwd_b = (mem_fwd && ex_mem.dest == id_ex.rt) ? FWD_MEM :
                   (wb_fwd && mem_wb.dest == id_ex.rt)  ? FWD_WB  : FWD_RF;

endmodule

// File: hw/mips_execute.sv
/*
 * Execute stage
 * ID/EX register with forwarded operands, ALU, beq/bne resolution,
 * overflow and misaligned address checks
 */
`timescale 1ns/1ps

module mips_execute
    import mips_pkg::*;
(
    input  logic     SYS_clk,
    input  logic     SYS_reset,
    id_ex_if.dst     id_ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  logic     exc_flush,
    input  word_t    mem_wb_result,
    ex_mem_if.src    ex_mem,
    output logic     branch_taken,
    output word_t    branch_target
);
    logic       q_valid;
    word_t      q_pc;
    word_t      q_imm;
    word_t      q_a;
    word_t      q_b;
    reg_addr_t  q_dest;
    alu_op_t    q_alu_op;
    logic       q_use_imm;
    logic       q_reg_write;
    logic       q_mem_read;
    logic       q_mem_write;
    logic       q_is_beq;
    logic       q_is_bne;
    exc_cause_t q_cause;
    word_t      opnd_b;
    word_t      sum;
    word_t      diff;
    logic       overflow;
    logic       misaligned;

    function automatic word_t pick(fwd_sel_t sel, word_t rf_val, word_t mem_val,
                                   word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            q_valid <= 1'b0;
        end
        else
        begin
            q_valid <= id_ex.valid && !branch_taken && !exc_flush;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        q_pc        <= id_ex.pc;
        q_imm       <= id_ex.imm;
        q_a         <= pick(fwd_a, id_ex.rs_val, ex_mem.alu_result, mem_wb_result);
        q_b         <= pick(fwd_b, id_ex.rt_val, ex_mem.alu_result, mem_wb_result);
        q_dest      <= id_ex.dest;
        q_alu_op    <= id_ex.alu_op;
        q_use_imm   <= id_ex.use_imm;
        q_reg_write <= id_ex.reg_write;
        q_mem_read  <= id_ex.mem_read;
        q_mem_write <= id_ex.mem_write;
        q_is_beq    <= id_ex.is_beq;
        q_is_bne    <= id_ex.is_bne;
        q_cause     <= id_ex.cause;
    end

    assign opnd_b = q_use_imm ? q_imm : q_b;
    assign sum    = q_a + opnd_b;
    assign diff   = q_a - opnd_b;

    always_comb
    begin
        case (q_alu_op)
            ALU_SUB: ex_mem.alu_result = diff;
            ALU_AND: ex_mem.alu_result = q_a & opnd_b;
            ALU_OR:  ex_mem.alu_result = q_a | opnd_b;
            ALU_SLT: ex_mem.alu_result = {31'b0, $signed(q_a) < $signed(opnd_b)};
            default: ex_mem.alu_result = sum;
        endcase
    end

    // arithmetic only, address adds never trap on overflow
    assign overflow = q_reg_write && !q_mem_read &&
                      ((q_alu_op == ALU_ADD && q_a[31] == opnd_b[31] && sum[31] != q_a[31]) ||
                       (q_alu_op == ALU_SUB && q_a[31] != opnd_b[31] && diff[31] != q_a[31]));
    assign misaligned = (q_mem_read || q_mem_write) && (sum[1:0] != 2'b00);

    assign ex_mem.cause = (q_cause != EXC_NONE) ? q_cause        :   // decode cause first
                          overflow              ? EXC_OVERFLOW   :
                          misaligned            ? EXC_MISALIGNED : EXC_NONE;

    assign ex_mem.valid      = q_valid;
    assign ex_mem.pc         = q_pc;
    assign ex_mem.store_data = q_b;
    assign ex_mem.dest       = q_dest;
    assign ex_mem.reg_write  = q_reg_write;
    assign ex_mem.mem_read   = q_mem_read;
    assign ex_mem.mem_write  = q_mem_write;

    assign branch_taken  = q_valid && ((q_is_beq && q_a == q_b) || (q_is_bne && q_a != q_b));
    assign branch_target = q_pc + 32'd4 + {q_imm[29:0], 2'b00};

endmodule

// File: hw/mips_memory.sv
/*
 * Memory stage
 * EX/MEM register, 64-word data memory, exception take and redirect
 */
`timescale 1ns/1ps

module mips_memory
    import mips_pkg::*;
(
    input  logic       SYS_clk,
    input  logic       SYS_reset,
    ex_mem_if.dst      ex_mem,
    mem_wb_if.src      mem_wb,
    output logic       exc_flush,
    output word_t      exc_target,
    output logic       exc_valid,
    output exc_cause_t exc_cause,
    output word_t      exc_epc
);
    logic       q_valid;
    word_t      q_pc;
    word_t      q_alu_result;
    word_t      q_store_data;
    reg_addr_t  q_dest;
    logic       q_reg_write;
    logic       q_mem_read;
    logic       q_mem_write;
    exc_cause_t q_cause;
    word_t      dmem [DMEM_WORDS];
    dmem_addr_t dmem_idx;
    logic       fault;
    logic       dmem_we;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            q_valid <= 1'b0;
        end
        else
        begin
            q_valid <= ex_mem.valid && !exc_flush;   // younger one dropped on a fault
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        q_pc         <= ex_mem.pc;
        q_alu_result <= ex_mem.alu_result;
        q_store_data <= ex_mem.store_data;
        q_dest       <= ex_mem.dest;
        q_reg_write  <= ex_mem.reg_write;
        q_mem_read   <= ex_mem.mem_read;
        q_mem_write  <= ex_mem.mem_write;
        q_cause      <= ex_mem.cause;
    end

    assign fault    = q_valid && (q_cause != EXC_NONE);
    assign dmem_idx = dmem_addr_t'(q_alu_result >> 2);
    assign dmem_we  = q_valid && !fault && q_mem_write;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
            begin
                dmem[i] <= '0;
            end
        end
        else if (dmem_we)
        begin
            dmem[dmem_idx] <= q_store_data;
        end
    end

    assign exc_flush  = fault;
    assign exc_valid  = fault;
    assign exc_target = q_pc + 32'd4;
    assign exc_epc    = q_pc;
    assign exc_cause  = fault ? q_cause : EXC_NONE;

    assign mem_wb.valid     = q_valid && !fault;
    assign mem_wb.pc        = q_pc;
    assign mem_wb.result    = q_mem_read ? dmem[dmem_idx] : q_alu_result;   // load reads same cycle
    assign mem_wb.dest      = q_dest;
    assign mem_wb.reg_write = q_reg_write;

endmodule

// File: hw/mips_writeback.sv
/*
 * Writeback stage
 * MEM/WB register, register-file write and retire report
 */
`timescale 1ns/1ps

module mips_writeback
    import mips_pkg::*;
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    mem_wb_if.dst     mem_wb,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,
    output logic      retire_valid,
    output word_t     retire_pc,
    output reg_addr_t retire_reg,
    output word_t     retire_data
);
    logic      q_we;
    word_t     q_pc;
    word_t     q_result;
    reg_addr_t q_dest;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            q_we <= 1'b0;
        end
        else
        begin
            q_we <= mem_wb.valid && mem_wb.reg_write;   // stores and branches stay silent
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        q_pc     <= mem_wb.pc;
        q_result <= mem_wb.result;
        q_dest   <= mem_wb.dest;
    end

    assign rf_we    = q_we;
    assign rf_waddr = q_dest;
    assign rf_wdata = q_result;

    // each register write is one retire event
    assign retire_valid = q_we;
    assign retire_pc    = q_pc;
    assign retire_reg   = q_dest;
    assign retire_data  = q_result;

endmodule

// File: hw/mips_core.sv
/*
 * MIPS five-stage pipeline top level
 * external instruction memory port, retire and exception report ports
 */
`timescale 1ns/1ps

module mips_core
    import mips_pkg::*;
(
    input  logic       SYS_clk,
    input  logic       SYS_reset,
    output word_t      imem_addr,
    input  word_t      imem_data,
    output logic       retire_valid,
    output word_t      retire_pc,
    output reg_addr_t  retire_reg,
    output word_t      retire_data,
    output logic       exc_valid,
    output exc_cause_t exc_cause,
    output word_t      exc_epc
);
    logic      stall;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    logic      branch_taken;
    word_t     branch_target;
    logic      exc_flush;
    word_t     exc_target;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    mem_wb_if mem_wb ();

    mips_fetch u_fetch (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .exc_flush     (exc_flush),
        .exc_target    (exc_target),
        .pc            (imem_addr)
    );

    mips_decode u_decode (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .instr        (imem_data),
        .fetch_pc     (imem_addr),
        .stall        (stall),
        .branch_taken (branch_taken),
        .exc_flush    (exc_flush),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .id_ex        (id_ex.src)
    );

    mips_hazard u_hazard (
        .id_ex      (id_ex.dst),
        .ex_mem     (ex_mem.dst),
        .mem_wb     (mem_wb.dst),
        .fetched_rs (id_ex.rs),
        .fetched_rt (id_ex.rt),
        .stall      (stall),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b)
    );

    mips_execute u_execute (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .id_ex         (id_ex.dst),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .exc_flush     (exc_flush),
        .mem_wb_result (mem_wb.result),
        .ex_mem        (ex_mem.src),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    mips_memory u_memory (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .ex_mem     (ex_mem.dst),
        .mem_wb     (mem_wb.src),
        .exc_flush  (exc_flush),
        .exc_target (exc_target),
        .exc_valid  (exc_valid),
        .exc_cause  (exc_cause),
        .exc_epc    (exc_epc)
    );

    mips_writeback u_writeback (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .mem_wb       (mem_wb.dst),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_reg   (retire_reg),
        .retire_data  (retire_data)
    );

endmodule

// File: verification/mips_ref_model.svh
/*
 * MIPS ISA reference model
 * random program generator and an in-order interpreter that builds
 * the queue of expected retire and exception events
 */
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

typedef struct packed
{
    logic       is_exc;
    word_t      pc;
    reg_addr_t  rd;
    word_t      data;
    exc_cause_t cause;
} exp_event_t;

word_t      prog_mem [PROG_WORDS];   // program image, word 0 at RESET_PC
exp_event_t exp_q [$];               // expected events in program order

function automatic int unsigned roll(int unsigned n);
    return $urandom % n;
endfunction

// mostly r1..r4 so neighbours collide often
function automatic reg_addr_t pick_reg();
    int unsigned r;
    r = roll(20);
    if (r == 0)
        return '0;
    if (r < 4)
        return reg_addr_t'(roll(32));
    return reg_addr_t'(1 + roll(4));
endfunction

function automatic logic [5:0] pick_funct();
    case (roll(5))
        0:       return FN_ADD;
        1:       return FN_SUB;
        2:       return FN_AND;
        3:       return FN_OR;
        default: return FN_SLT;
    endcase
endfunction

// r0-relative offset inside the data memory, now and then misaligned
function automatic logic [15:0] mem_offset();
    logic [15:0] off;
    off = 16'(roll(DMEM_WORDS) * 4);
    if (roll(12) == 0)
        off = off + 16'(1 + roll(3));
    return off;
endfunction

function automatic word_t illegal_word();
    logic [5:0] op;
    logic [5:0] fn;
    if (roll(2) == 0)
    begin
        fn = 6'(roll(64));
        if (fn inside {6'h00, FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT})
            fn = 6'h3f;   // keeps the word nonzero too
        return {OP_RTYPE, 5'(roll(32)), 5'(roll(32)), 5'(roll(32)), 5'd0, fn};
    end
    op = 6'(roll(64));
    if (op inside {OP_RTYPE, OP_ADDI, OP_LW, OP_SW, OP_BEQ, OP_BNE})
        op = 6'h3f;
    return {op, 26'($urandom)};
endfunction

function automatic word_t make_instr();
    int unsigned kind;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    kind = roll(100);
    rs   = pick_reg();
    rt   = pick_reg();
    rd   = pick_reg();
    if (kind < 20)
        return {OP_RTYPE, rs, rt, rd, 5'd0, pick_funct()};
    if (kind < 28)
        return {OP_RTYPE, rd, rd, rd, 5'd0, FN_ADD};   // doubling, heads for overflow
    if (kind < 45)
        return {OP_ADDI, rs, rt, 16'($urandom)};
    if (kind < 60)
        return {OP_LW, 5'd0, rt, mem_offset()};
    if (kind < 72)
        return {OP_SW, 5'd0, rt, mem_offset()};
    if (kind < 82)
        return {(roll(2) == 0) ? OP_BEQ : OP_BNE, rs, rt, 16'(roll(4))};   // forward only
    if (kind < 88)
        return illegal_word();
    if (kind < 92)
        return '0;
    return {OP_ADDI, rs, rt, 16'(roll(16))};
endfunction

task automatic build_program();
    for (int i = 0; i < PROG_WORDS; i++)
    begin
        prog_mem[i] = make_instr();
    end
endtask

function automatic void expect_retire(word_t pc, reg_addr_t rd, word_t data);
    exp_event_t ev;
    ev.is_exc = 1'b0;
    ev.pc     = pc;
    ev.rd     = rd;
    ev.data   = data;
    ev.cause  = EXC_NONE;
    exp_q.push_back(ev);
endfunction

function automatic void expect_exc(exc_cause_t cause, word_t epc);
    exp_event_t ev;
    ev.is_exc = 1'b1;
    ev.pc     = epc;
    ev.rd     = '0;
    ev.data   = '0;
    ev.cause  = cause;
    exp_q.push_back(ev);
endfunction

// architectural interpreter, one instruction at a time
task automatic run_model();
    word_t      regs [32];
    word_t      dmem [DMEM_WORDS];
    word_t      pc;
    word_t      next_pc;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      imm;
    word_t      res;
    reg_addr_t  dest;
    logic       writes;
    logic       illegal;
    logic       ovf;
    logic       bad_addr;
    logic       taken;
    longint     wide;
    exc_cause_t cause;
    for (int i = 0; i < 32; i++)
        regs[i] = '0;
    for (int i = 0; i < DMEM_WORDS; i++)
        dmem[i] = '0;
    pc = RESET_PC;
    while (pc - RESET_PC < PROG_WORDS * 4)
    begin
        ins     = prog_mem[(pc - RESET_PC) >> 2];
        next_pc = pc + 32'd4;
        if (ins == '0)
        begin
            pc = next_pc;   // nop
            continue;
        end
        a        = regs[ins[25:21]];
        b        = regs[ins[20:16]];
        imm      = {{16{ins[15]}}, ins[15:0]};
        dest     = ins[20:16];
        res      = '0;
        writes   = 1'b0;
        illegal  = 1'b0;
        ovf      = 1'b0;
        bad_addr = 1'b0;
        taken    = 1'b0;
        case (ins[31:26])
            OP_RTYPE:
            begin
                dest   = ins[15:11];
                writes = 1'b1;
                case (ins[5:0])
                    FN_ADD:
                    begin
                        res  = a + b;
                        wide = longint'($signed(a)) + longint'($signed(b));
                        ovf  = wide != longint'($signed(res));
                    end
                    FN_SUB:
                    begin
                        res  = a - b;
                        wide = longint'($signed(a)) - longint'($signed(b));
                        ovf  = wide != longint'($signed(res));
                    end
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: illegal = 1'b1;
                endcase
            end
            OP_ADDI:
            begin
                writes = 1'b1;
                res    = a + imm;
                wide   = longint'($signed(a)) + longint'($signed(imm));
                ovf    = wide != longint'($signed(res));
            end
            OP_LW, OP_SW:
            begin
                writes   = ins[31:26] == OP_LW;
                res      = a + imm;   // byte address
                bad_addr = res[1:0] != 2'b00;
            end
            OP_BEQ:  taken = a == b;
            OP_BNE:  taken = a != b;
            default: illegal = 1'b1;
        endcase
        if (illegal)
            cause = EXC_ILLEGAL;
        else if (writes && dest == '0)
            cause = EXC_ZERO_WRITE;
        else if (ovf)
            cause = EXC_OVERFLOW;
        else if (bad_addr)
            cause = EXC_MISALIGNED;
        else
            cause = EXC_NONE;
        if (cause != EXC_NONE)
        begin
            expect_exc(cause, pc);   // resumes at pc + 4
        end
        else
        begin
            if (ins[31:26] == OP_SW)
                dmem[res[7:2]] = b;
            if (ins[31:26] == OP_LW)
                res = dmem[res[7:2]];
            if (taken)
                next_pc = pc + 32'd4 + (imm << 2);
            if (writes)
            begin
                regs[dest] = res;
                expect_retire(pc, dest, res);
            end
        end
        pc = next_pc;
    end
endtask

`endif

// File: verification/mips_tb.sv
/*
 * Testbench for the MIPS pipeline
 * random program against an ISA model, retire and exception
 * streams checked in program order
 */
`timescale 1ns/1ps

module mips_tb
    import mips_pkg::*;
();
    localparam int          PROG_WORDS      = 200;
    localparam int          TAIL_CYCLES     = 20;
    localparam int          WATCHDOG_CYCLES = PROG_WORDS * 4 + 100;
    localparam int unsigned SEED            = 32'h7c30224f;

    logic        SYS_clk;
    logic        SYS_reset;
    word_t       imem_addr;
    word_t       imem_data;
    word_t       imem_off;
    logic        retire_valid;
    word_t       retire_pc;
    reg_addr_t   retire_reg;
    word_t       retire_data;
    logic        exc_valid;
    exc_cause_t  exc_cause;
    word_t       exc_epc;
    int unsigned seed;

    `include "mips_ref_model.svh"

    mips_core u_dut (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_reg   (retire_reg),
        .retire_data  (retire_data),
        .exc_valid    (exc_valid),
        .exc_cause    (exc_cause),
        .exc_epc      (exc_epc)
    );

    always #2 SYS_clk = ~SYS_clk;   // 4 ns period

    // outside the program the bus reads as a nop
    assign imem_off  = imem_addr - RESET_PC;
    assign imem_data = (imem_off < PROG_WORDS * 4 && imem_off[1:0] == 2'b00) ?
                       prog_mem[imem_off[31:2]] : '0;

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_error(string what);
        $display("%0d ns: %s", $time, what);
        stop_run();
    endtask

    task automatic report_value(string sig, word_t got, word_t want);
        $display("FAILED at %0d ns: %s = %0h, expected %0h", $time, sig, got, want);
        stop_run();
    endtask

    task automatic check_retire(word_t pc, reg_addr_t rd, word_t data, exp_event_t want);
        if (pc != want.pc)
            report_value("retire_pc", pc, want.pc);
        if (rd != want.rd)
            report_value("retire_reg", word_t'(rd), word_t'(want.rd));
        if (data != want.data)
            report_value("retire_data", data, want.data);
    endtask

    task automatic check_exc(exc_cause_t cause, word_t epc, exp_event_t want);
        if (cause != want.cause)
            report_value("exc_cause", word_t'(cause), word_t'(want.cause));
        if (epc != want.pc)
            report_value("exc_epc", epc, want.pc);
    endtask

    // an older retire and a younger fault can share a cycle, retire first
    always @(posedge SYS_clk)
    begin
        if (retire_valid === 1'b1)
        begin
            if (exp_q.size() == 0)
                report_error($sformatf("retire of pc %0h after the last expected event",
                                       retire_pc));
            else if (exp_q[0].is_exc)
                report_error($sformatf("retire of pc %0h where an exception at %0h was due",
                                       retire_pc, exp_q[0].pc));
            else
                check_retire(retire_pc, retire_reg, retire_data, exp_q.pop_front());
        end
        if (exc_valid === 1'b1)
        begin
            if (exp_q.size() == 0)
                report_error($sformatf("exception at pc %0h after the last expected event",
                                       exc_epc));
            else if (!exp_q[0].is_exc)
                report_error($sformatf("exception at pc %0h where a retire of %0h was due",
                                       exc_epc, exp_q[0].pc));
            else
                check_exc(exc_cause, exc_epc, exp_q.pop_front());
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge SYS_clk);
        report_error($sformatf("watchdog expired with %0d expected events outstanding",
                               exp_q.size()));
    end

    initial
    begin
        SYS_clk   = 1'b0;
        SYS_reset = 1'b1;
        seed      = SEED;
        void'($urandom(seed));
        build_program();
        run_model();
        $display("program of %0d words, %0d expected events", PROG_WORDS, exp_q.size());
        repeat (4) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
        while (exp_q.size() != 0)
            @(posedge SYS_clk);
        repeat (TAIL_CYCLES) @(posedge SYS_clk);   // catch stray events
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verification
hw/mips_pkg.sv
hw/mips_pipe_if.sv
hw/mips_fetch.sv
hw/mips_decode.sv
hw/mips_hazard.sv
hw/mips_execute.sv
hw/mips_memory.sv
hw/mips_writeback.sv
hw/mips_core.sv
verification/mips_tb.sv

// File: Bender.yml
package:
  name: mips_pipeline

sources:
  - hw/mips_pkg.sv
  - hw/mips_pipe_if.sv
  - hw/mips_fetch.sv
  - hw/mips_decode.sv
  - hw/mips_hazard.sv
  - hw/mips_execute.sv
  - hw/mips_memory.sv
  - hw/mips_writeback.sv
  - hw/mips_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/mips_tb.sv
